/* src/com_pkg.sv */
package com_pkg;

    // ######################################################################
    // Frame format
    // ######################################################################

    // Bit value that opens a frame while fire is high.
    localparam logic SYNC_BIT = 1'b1;

    // Data bits per word, sent MSB first.
    localparam int WORD_BITS = 8;

    // ######################################################################
    // Lane skew buffering
    // ######################################################################

    // Words each lane may run ahead of the other.
    localparam int PAIR_DEPTH = 4;
    localparam int PAIR_PTR_BITS = $clog2(PAIR_DEPTH);
    localparam int PAIR_CNT_BITS = $clog2(PAIR_DEPTH + 1);

endpackage

/* src/link_pkg.sv */
package link_pkg;

    import com_pkg::*;

    // ######################################################################
    // Word types on the receive path
    // ######################################################################

    // One deserialized word from a single lane.
    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] data;
    } lane_word_t;

    // Matched words from both lanes, lane 0 in lo and lane 1 in hi.
    typedef struct packed {
        logic                 valid;
        logic [WORD_BITS-1:0] lo;
        logic [WORD_BITS-1:0] hi;
    } pair_word_t;

endpackage

/* src/com_rxf.sv */
`timescale 1ns/1ps

module com_rxf
    import com_pkg::*;
    import link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       din,
    input  logic       fire,
    output lane_word_t word
);

    typedef enum logic [3:0] {
        ST_WAIT,
        ST_HUNT,
        ST_B0,
        ST_B1,
        ST_B2,
        ST_B3,
        ST_B4,
        ST_B5,
        ST_B6,
        ST_B7
    } state_t;

    state_t state;
    state_t state_nxt;

    logic [WORD_BITS-2:0] shreg;
    logic [WORD_BITS-1:0] word_data;
    logic                 word_valid;
    logic                 shift_en;

    // ######################################################################
    // Frame state machine
    // ######################################################################

    always_comb begin
        state_nxt = state;
        case (state)
            // Fire going high already counts as hunting on this edge.
            ST_WAIT: begin
                if (fire) begin
                    state_nxt = (din == SYNC_BIT) ? ST_B0 : ST_HUNT;
                end
            end
            ST_HUNT: begin
                if (!fire) begin
                    state_nxt = ST_WAIT;
                end else if (din == SYNC_BIT) begin
                    state_nxt = ST_B0;
                end
            end
            ST_B0: state_nxt = ST_B1;
            ST_B1: state_nxt = ST_B2;
            ST_B2: state_nxt = ST_B3;
            ST_B3: state_nxt = ST_B4;
            ST_B4: state_nxt = ST_B5;
            ST_B5: state_nxt = ST_B6;
            ST_B6: state_nxt = ST_B7;
            // No new sync bit between back-to-back words.
            ST_B7: state_nxt = fire ? ST_B0 : ST_WAIT;
            default: state_nxt = ST_WAIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_WAIT;
            word_valid <= 1'b0;
        end else begin
            state      <= state_nxt;
            word_valid <= (state == ST_B7);
        end
    end

    // ######################################################################
    // Deserializer
    // ######################################################################

    assign shift_en = state inside {ST_B0, ST_B1, ST_B2, ST_B3, ST_B4, ST_B5, ST_B6};

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {shreg[WORD_BITS-3:0], din};
        end
        // Last bit goes straight into the word.
        if (state == ST_B7) begin
            word_data <= {shreg, din};
        end
    end

    assign word = lane_word_t'{valid: word_valid, data: word_data};

    // Eight bit states lie between two strobes.
    a_valid_spacing: assert property (
        @(posedge clk) disable iff (rst) word_valid |=> !word_valid
    );

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {ST_WAIT, ST_HUNT, ST_B0, ST_B1, ST_B2,
                      ST_B3, ST_B4, ST_B5, ST_B6, ST_B7}
    );

endmodule

/* src/lane_pair.sv */
`timescale 1ns/1ps

module lane_pair
    import com_pkg::*;
    import link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lane_word_t lane0,
    input  lane_word_t lane1,
    output pair_word_t pair,
    output logic       skew_error
);

    localparam int LANES = 2;

    lane_word_t lane_in [LANES];

    logic [WORD_BITS-1:0]     buf_mem [LANES][PAIR_DEPTH];
    logic [PAIR_PTR_BITS-1:0] wr_ptr  [LANES];
    logic [PAIR_PTR_BITS-1:0] rd_ptr  [LANES];
    logic [PAIR_CNT_BITS-1:0] cnt     [LANES];

    logic [LANES-1:0] full;
    logic [LANES-1:0] store;
    logic [LANES-1:0] drop;
    logic             pop;

    logic                 pair_valid;
    logic [WORD_BITS-1:0] pair_lo;
    logic [WORD_BITS-1:0] pair_hi;

    function automatic logic [PAIR_PTR_BITS-1:0] next_ptr(
        input logic [PAIR_PTR_BITS-1:0] ptr
    );
        return (ptr == PAIR_PTR_BITS'(PAIR_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign lane_in[0] = lane0;
    assign lane_in[1] = lane1;

    // ######################################################################
    // Buffer control
    // ######################################################################

    // Only buffered words pair up, never a word arriving this cycle.
    assign pop = (cnt[0] != '0) && (cnt[1] != '0);

    always_comb begin
        for (int n = 0; n < LANES; n++) begin
            full[n]  = (cnt[n] == PAIR_CNT_BITS'(PAIR_DEPTH));
            // A pop on the same edge frees the slot.
            store[n] = lane_in[n].valid && (!full[n] || pop);
            drop[n]  = lane_in[n].valid && full[n] && !pop;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int n = 0; n < LANES; n++) begin
                wr_ptr[n] <= '0;
                rd_ptr[n] <= '0;
                cnt[n]    <= '0;
            end
            pair_valid <= 1'b0;
            skew_error <= 1'b0;
        end else begin
            for (int n = 0; n < LANES; n++) begin
                if (store[n]) begin
                    wr_ptr[n] <= next_ptr(wr_ptr[n]);
                end
                if (pop) begin
                    rd_ptr[n] <= next_ptr(rd_ptr[n]);
                end
                cnt[n] <= cnt[n] + PAIR_CNT_BITS'(store[n]) - PAIR_CNT_BITS'(pop);
            end
            pair_valid <= pop;
            // Sticky until reset.
            if (|drop) begin
                skew_error <= 1'b1;
            end
        end
    end

    // ######################################################################
    // Storage and pair output
    // ######################################################################

    always_ff @(posedge clk) begin
        for (int n = 0; n < LANES; n++) begin
            if (store[n]) begin
                buf_mem[n][wr_ptr[n]] <= lane_in[n].data;
            end
        end
        if (pop) begin
            pair_lo <= buf_mem[0][rd_ptr[0]];
            pair_hi <= buf_mem[1][rd_ptr[1]];
        end
    end

    assign pair = pair_word_t'{valid: pair_valid, lo: pair_lo, hi: pair_hi};

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (rst)
        (cnt[0] <= PAIR_CNT_BITS'(PAIR_DEPTH)) && (cnt[1] <= PAIR_CNT_BITS'(PAIR_DEPTH))
    );

    // A pair always comes from two buffered words, judged by the pointers.
    a_pair_source: assert property (
        @(posedge clk) disable iff (rst)
        pair_valid |-> $past(((wr_ptr[0] != rd_ptr[0]) || full[0])
                          && ((wr_ptr[1] != rd_ptr[1]) || full[1]))
    );

endmodule

/* src/com_rx_top.sv */
`timescale 1ns/1ps

module com_rx_top
    import link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] din,
    input  logic [1:0] fire,
    output pair_word_t pair,
    output logic       skew_error
);

    lane_word_t lane_word [2];

    // ######################################################################
    // Lane receivers
    // ######################################################################

    com_rxf i_rxf_0 (
        .clk  (clk),
        .rst  (rst),
        .din  (din[0]),
        .fire (fire[0]),
        .word (lane_word[0])
    );

    com_rxf i_rxf_1 (
        .clk  (clk),
        .rst  (rst),
        .din  (din[1]),
        .fire (fire[1]),
        .word (lane_word[1])
    );

    // Deskew and join the two lanes.
    lane_pair i_lane_pair (
        .clk        (clk),
        .rst        (rst),
        .lane0      (lane_word[0]),
        .lane1      (lane_word[1]),
        .pair       (pair),
        .skew_error (skew_error)
    );

endmodule

/* verification/tb_com_rx.sv */
`timescale 1ns/1ps

module tb_com_rx
    import com_pkg::*;
    import link_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int PAIR_TIMEOUT = 200;
    localparam int MAX_WORDS = 8;

    logic       clk;
    logic       rst;
    logic [1:0] din;
    logic [1:0] fire;
    pair_word_t pair;
    logic       skew_error;

    logic [31:0]          lfsr_state;
    logic [WORD_BITS-1:0] tx_words [2][MAX_WORDS];
    logic [WORD_BITS-1:0] got_lo [$];
    logic [WORD_BITS-1:0] got_hi [$];
    time                  got_time [$];
    time                  last_edge [2];

    com_rx_top i_com_rx_top (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .fire       (fire),
        .pair       (pair),
        .skew_error (skew_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Pairs are sampled on the falling edge, away from the driving edge.
    always @(negedge clk) begin
        if (!rst && pair.valid) begin
            got_lo.push_back(pair.lo);
            got_hi.push_back(pair.hi);
            got_time.push_back($time);
        end
    end

    // ######################################################################
    // Helpers
    // ######################################################################

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [WORD_BITS-1:0] b);
        for (int i = 0; i < WORD_BITS; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[WORD_BITS-2:0], lfsr_state[0]};
        end
    endtask

    task automatic fill_words(input int n);
        for (int lane = 0; lane < 2; lane++) begin
            for (int i = 0; i < n; i++) begin
                random_byte(tx_words[lane][i]);
            end
        end
    endtask

    task automatic clear_results();
        got_lo.delete();
        got_hi.delete();
        got_time.delete();
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst  <= 1'b1;
        din  <= '0;
        fire <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Serializes idle ones, hunt zeros, the sync bit and then the words.
    task automatic send_lane(input int lane, input int delay, input int nwords,
                             input int idle_ones, input int lead_zeros);
        repeat (delay) @(posedge clk);
        repeat (idle_ones) begin
            @(posedge clk);
            fire[lane] <= 1'b0;
            din[lane]  <= 1'b1;
        end
        repeat (lead_zeros) begin
            @(posedge clk);
            fire[lane] <= 1'b1;
            din[lane]  <= 1'b0;
        end
        @(posedge clk);
        fire[lane] <= 1'b1;
        din[lane]  <= SYNC_BIT;
        for (int w = 0; w < nwords; w++) begin
            for (int b = WORD_BITS - 1; b >= 0; b--) begin
                @(posedge clk);
                din[lane] <= tx_words[lane][w][b];
                // Fire drops with the last bit, so the receiver goes back to wait.
                fire[lane] <= !((w == nwords - 1) && (b == 0));
            end
        end
        @(posedge clk);
        last_edge[lane] = $time;
        din[lane] <= 1'b0;
    endtask

    task automatic wait_pairs(input int n);
        int cycles;
        cycles = 0;
        while (got_lo.size() < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > PAIR_TIMEOUT) begin
                stop_run("Timed out waiting for word pairs from the DUT.");
            end
        end
    endtask

    task automatic wait_skew_error();
        int cycles;
        cycles = 0;
        while (skew_error !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > PAIR_TIMEOUT) begin
                stop_run("Timed out waiting for skew_error to rise.");
            end
        end
    endtask

    // The n-th lane 0 word goes with the n-th lane 1 word.
    task automatic check_pairs(input int n);
        check("pair count", got_lo.size(), n);
        for (int i = 0; i < n; i++) begin
            check("pair.lo", got_lo[i], tx_words[0][i]);
            check("pair.hi", got_hi[i], tx_words[1][i]);
        end
    endtask

    // ######################################################################
    // Directed tests
    // ######################################################################

    task automatic test_aligned();
        clear_results();
        fill_words(1);
        fork
            send_lane(0, 0, 1, 0, 0);
            send_lane(1, 0, 1, 0, 0);
        join
        wait_pairs(1);
        idle_cycles(12);
        check_pairs(1);
        // Two edges after the last bit, seen at the next falling edge.
        check("pair latency", got_time[0] - last_edge[1], 2 * CLK_PERIOD + CLK_PERIOD / 2);
        check("skew_error", skew_error, 1'b0);
    endtask

    task automatic test_back_to_back();
        clear_results();
        fill_words(6);
        fork
            send_lane(0, 0, 6, 0, 0);
            send_lane(1, 0, 6, 0, 0);
        join
        wait_pairs(6);
        idle_cycles(12);
        check_pairs(6);
        check("skew_error", skew_error, 1'b0);
    endtask

    task automatic test_skew();
        clear_results();
        fill_words(4);
        fork
            send_lane(0, 0, 4, 0, 0);
            send_lane(1, 19, 4, 0, 0);
        join
        wait_pairs(4);
        idle_cycles(12);
        check_pairs(4);
        check("skew_error", skew_error, 1'b0);
    endtask

    task automatic test_hunt_idle();
        clear_results();
        fill_words(2);
        fork
            send_lane(0, 0, 2, 5, 3);
            send_lane(1, 0, 2, 4, 7);
        join
        wait_pairs(2);
        idle_cycles(12);
        check_pairs(2);
        check("skew_error", skew_error, 1'b0);
    endtask

    task automatic test_overflow();
        clear_results();
        fill_words(5);
        send_lane(0, 0, 5, 0, 0);
        wait_skew_error();
        check("pair count", got_lo.size(), 0);
        send_lane(1, 0, 4, 0, 0);
        wait_pairs(4);
        idle_cycles(12);
        check_pairs(4);
        check("skew_error", skew_error, 1'b1);
        reset_dut();
        @(negedge clk);
        check("skew_error", skew_error, 1'b0);
    endtask

    initial begin
        rst        = 1'b1;
        din        = '0;
        fire       = '0;
        lfsr_state = 32'h9148;
        reset_dut();
        idle_cycles(2);
        test_aligned();
        test_back_to_back();
        test_skew();
        test_hunt_idle();
        test_overflow();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* list.f */
src/com_pkg.sv
src/link_pkg.sv
src/com_rxf.sv
src/lane_pair.sv
src/com_rx_top.sv
verification/tb_com_rx.sv

/* Makefile */
TOP := tb_com_rx

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
